// File: verif/fft_cases.txt
// per frame: 8 input words (samples 0..7) then 8 expected words (bins 0..7)
// each word is {re, im}, both 16-bit two's complement, four words per line

// dc level (1000, -2000)
03E8F830 03E8F830 03E8F830 03E8F830
03E8F830 03E8F830 03E8F830 03E8F830
03E8F830 00000000 00000000 00000000
00000000 00000000 00000000 00000000

// single sample (4096, 0) at n=1
00000000 10000000 00000000 00000000
00000000 00000000 00000000 00000000
02000000 016AFE95 0000FE00 FE95FE95
FE000000 FE96016A 00000200 016A016A

// alternating sign (800, 300)
0320012C FCE0FED4 0320012C FCE0FED4
0320012C FCE0FED4 0320012C FCE0FED4
00000000 00000000 00000000 00000000
0320012C 00000000 00000000 00000000

// mixed small values, exercises floor rounding
00640000 000000C8 FED40000 00000000
0032FFCE 00000000 00000000 00070003
FFED0012 0018003D 0050FFFA 0016FFCF
FFECFFE0 FFF40019 001FFFF8 FFF5FFF2

// single large sample (20000, -10000) at n=3
00000000 00000000 00000000 4E20D8F0
00000000 00000000 00000000 00000000
09C4FB1E F5A4FC8B 04E209C4 0374F5A4
F63C04E2 0A5B0374 FB1EF63C FC8C0A5C

// File: tb.f
+incdir+include
logic/fft_pkg.sv
logic/fft_ctrl.sv
logic/fft_addr_counter.sv
logic/fft_sample_ram.sv
logic/fft_butterfly.sv
logic/fft_core.sv
verif/fft_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the FFT testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module fft_tb -o fft_sim

./obj_dir/fft_sim 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// File: verif/fft_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_params.svh"

module fft_tb;
    import fft_pkg::*;

    // one {re, im} word as stored in the cases file
    typedef logic [2*`FFT_DW-1:0] wordT;

    localparam int NUM_FRAMES      = 5;
    localparam int WORDS_PER_FRAME = 2 * `FFT_N;
    localparam int LOAD_LIMIT      = 200;
    localparam int UNLOAD_LIMIT    = 500;

    logic        clk;
    logic        reset_i;
    logic        in_valid_i;
    cplxT        in_sample_i;
    logic        out_ready_i;
    logic        in_ready_o;
    logic        out_valid_o;
    cplxT        out_sample_o;
    logic        out_last_o;

    wordT        caseMem [NUM_FRAMES * WORDS_PER_FRAME];
    wordT        frameIn [`FFT_N];
    wordT        frameExp [`FFT_N];

    fft_core dut0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .in_valid_i   (in_valid_i),
        .in_sample_i  (in_sample_i),
        .out_ready_i  (out_ready_i),
        .in_ready_o   (in_ready_o),
        .out_valid_o  (out_valid_o),
        .out_sample_o (out_sample_o),
        .out_last_o   (out_last_o)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // copy one frame out of the cases memory
    task automatic fetchFrame(input int frameIdx);
        int base;
        base = frameIdx * WORDS_PER_FRAME;
        for (int i = 0; i < `FFT_N; i++)
        begin
            frameIn[i]  = caseMem[base + i];
            frameExp[i] = caseMem[base + `FFT_N + i];
        end
    endtask

    // (8,0) at sample 0, DFT/8 is (1,0) in every bin
    task automatic buildImpulse();
        for (int i = 0; i < `FFT_N; i++)
        begin
            frameIn[i]  = '0;
            frameExp[i] = {16'sd1, 16'sd0};
        end
        frameIn[0] = {16'sd8, 16'sd0};
    endtask

    // feed eight samples, optionally with random valid gaps
    task automatic loadFrame(input bit stress);
        int idx;
        int cycles;
        idx    = 0;
        cycles = 0;
        while (idx < `FFT_N)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > LOAD_LIMIT)
                stopOnError("timeout, the DUT did not take all eight input samples");
            assert (in_ready_o)
            else
                stopOnError("in_ready_o was low while a frame was being loaded");
            assert (!out_valid_o)
            else
                stopOnError("out_valid_o was high while a frame was being loaded");
            if (stress && ($urandom % 4 == 0))
            begin
                // gap with junk payload
                in_valid_i  = 1'b0;
                in_sample_i = cplxT'($urandom);
            end
            else
            begin
                in_valid_i  = 1'b1;
                in_sample_i = cplxT'(frameIn[idx]);
                idx++;
            end
        end
    endtask

    // collect eight bins, compare in natural order
    task automatic unloadFrame(input bit stress);
        int   got;
        int   cycles;
        bit   holding;
        cplxT heldSample;
        logic heldLast;
        got        = 0;
        cycles     = 0;
        holding    = 1'b0;
        heldSample = '0;
        heldLast   = 1'b0;
        while (got < `FFT_N)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > UNLOAD_LIMIT)
                stopOnError($sformatf("timeout, only %0d of eight bins came out", got));
            assert (!in_ready_o)
            else
                stopOnError("in_ready_o went high before the unload ended");
            // stray pulses while input is gated
            in_valid_i  = stress ? 1'($urandom % 2) : 1'b0;
            in_sample_i = cplxT'($urandom);
            // a stalled bin must not move
            if (holding)
            begin
                assert (out_valid_o)
                else
                    stopOnError("out_valid_o dropped before its value was taken");
                assert (out_sample_o == heldSample)
                else
                    stopOnError($sformatf("Fail out_sample_o held expected %h got %h",
                                          heldSample, out_sample_o));
                assert (out_last_o == heldLast)
                else
                    stopOnError($sformatf("Fail out_last_o held expected %h got %h",
                                          heldLast, out_last_o));
            end
            out_ready_i = stress ? (($urandom % 3) != 0) : 1'b1;
            holding     = out_valid_o && !out_ready_i;
            heldSample  = out_sample_o;
            heldLast    = out_last_o;
            if (out_valid_o && out_ready_i)
            begin
                assert (out_sample_o == frameExp[got])
                else
                    stopOnError($sformatf("Fail out_sample_o bin %0d expected %h got %h",
                                          got, frameExp[got], out_sample_o));
                assert (out_last_o == (got == `FFT_N - 1))
                else
                    stopOnError($sformatf("Fail out_last_o bin %0d expected %h got %h",
                                          got, (got == `FFT_N - 1), out_last_o));
                got++;
            end
        end
    endtask

    task automatic runFrame(input bit stress);
        loadFrame(stress);
        unloadFrame(stress);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        void'($urandom(91940));
        clk         = 1'b0;
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        in_sample_i = '0;
        out_ready_i = 1'b0;
        $readmemh("verif/fft_cases.txt", caseMem);

        // five cycles of reset
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        assert (in_ready_o)
        else
            stopOnError($sformatf("Fail in_ready_o after reset expected 1 got %h", in_ready_o));
        assert (!out_valid_o)
        else
            stopOnError($sformatf("Fail out_valid_o after reset expected 0 got %h",
                                  out_valid_o));

        buildImpulse();
        runFrame(1'b0);

        // clean pass then gaps, back-pressure and stray valids
        for (int pass = 0; pass < 2; pass++)
        begin
            for (int f = 0; f < NUM_FRAMES; f++)
            begin
                fetchFrame(f);
                runFrame(pass == 1);
            end
        end

        in_valid_i = 1'b0;
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/fft_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_params.svh"

module fft_core
(
    input  wire logic          clk,
    input  wire logic          reset_i,
    input  wire logic          in_valid_i,
    input  wire fft_pkg::cplxT in_sample_i,
    input  wire logic          out_ready_i,
    output logic               in_ready_o,
    output logic               out_valid_o,
    output fft_pkg::cplxT      out_sample_o,
    output logic               out_last_o
);
    import fft_pkg::*;

    fftStateT state;
    logic     inFire;
    logic     outFire;
    logic     loadDone;
    logic     stageDone;
    logic     drainDone;
    logic     lastStage;
    logic     unloadDone;
    addrT     loadAddr;
    addrT     unloadAddr;
    bflyReqT  req;
    bflyResT  res;
    cplxT     rdA;
    cplxT     rdB;
    cplxT     unloadData;
    logic     unloadPrimed;
    logic     loadOut;

    // input only while a frame is being collected
    assign in_ready_o = (state == IDLE) || (state == LOAD);
    assign inFire     = in_valid_i && in_ready_o;
    assign outFire    = out_valid_o && out_ready_i;

    fft_ctrl ctrl0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .loadDone_i   (loadDone),
        .stageDone_i  (stageDone),
        .drainDone_i  (drainDone),
        .lastStage_i  (lastStage),
        .unloadDone_i (unloadDone),
        .state_o      (state)
    );

    fft_addr_counter cnt0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .state_i      (state),
        .inFire_i     (inFire),
        .outFire_i    (outFire),
        .loadDone_o   (loadDone),
        .stageDone_o  (stageDone),
        .drainDone_o  (drainDone),
        .lastStage_o  (lastStage),
        .unloadDone_o (unloadDone),
        .loadAddr_o   (loadAddr),
        .unloadAddr_o (unloadAddr),
        .req_o        (req)
    );

    fft_sample_ram ram0 (
        .clk          (clk),
        .inFire_i     (inFire),
        .loadAddr_i   (loadAddr),
        .in_sample_i  (in_sample_i),
        .req_i        (req),
        .res_i        (res),
        .unloadAddr_i (unloadAddr),
        .rdA_o        (rdA),
        .rdB_o        (rdB),
        .unloadData_o (unloadData)
    );

    fft_butterfly bfly0 (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (req),
        .a_i     (rdA),
        .b_i     (rdB),
        .res_o   (res)
    );

    //////////////////////////////
    // output holding register
    //////////////////////////////

    // read data matches the unload index once a full unload cycle has passed
    assign loadOut = (state == UNLOAD) && unloadPrimed && !out_valid_o;

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            unloadPrimed <= 1'b0;
            out_valid_o  <= 1'b0;
            out_last_o   <= 1'b0;
        end
        else
        begin
            unloadPrimed <= (state == UNLOAD);
            if (outFire)
            begin
                out_valid_o <= 1'b0;
                out_last_o  <= 1'b0;
            end
            else if (loadOut)
            begin
                out_valid_o <= 1'b1;
                out_last_o  <= (unloadAddr == addrT'(`FFT_N - 1));
            end
        end
    end

    // payload only
    always_ff @(posedge clk)
    begin
        if (loadOut)
            out_sample_o <= unloadData;
    end

    // the last flag agrees with the unload count on every transfer
    lastAtFinalBin: assert property (@(posedge clk) disable iff (reset_i)
        outFire |-> (out_last_o == unloadDone));

endmodule

`default_nettype wire

// File: logic/fft_butterfly.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_params.svh"

module fft_butterfly
(
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire fft_pkg::bflyReqT req_i,
    input  wire fft_pkg::cplxT    a_i,
    input  wire fft_pkg::cplxT    b_i,
    output fft_pkg::bflyResT      res_o
);
    import fft_pkg::*;

    // W_k = cos(2pi k/8) - j sin(2pi k/8) in Q1.14
    localparam twiddleT twReTable [4] = '{16'sd16384, 16'sd11585, 16'sd0, -16'sd11585};
    localparam twiddleT twImTable [4] = '{16'sd0, -16'sd11585, -16'sd16384, -16'sd11585};

    bflyReqT                          reqD1;
    bflyReqT                          reqD2;
    twiddleT                          twRe;
    twiddleT                          twIm;
    sampleT                           bRe;
    sampleT                           bIm;
    logic signed [`FFT_DW+`FFT_TW-1:0] prodRR;
    logic signed [`FFT_DW+`FFT_TW-1:0] prodII;
    logic signed [`FFT_DW+`FFT_TW-1:0] prodRI;
    logic signed [`FFT_DW+`FFT_TW-1:0] prodIR;
    cplxT                             tProd;
    cplxT                             tReg;
    cplxT                             aReg;
    sampleT                           sumRe;
    sampleT                           sumIm;
    sampleT                           difRe;
    sampleT                           difIm;

    //////////////////////////////
    // stage 1 twiddle multiply
    //////////////////////////////

    // reqD1 lines up with the memory read data
    always_comb
    begin
        twRe   = twReTable[reqD1.twIdx];
        twIm   = twImTable[reqD1.twIdx];
        bRe    = b_i.re;
        bIm    = b_i.im;
        prodRR = bRe * twRe;
        prodII = bIm * twIm;
        prodRI = bRe * twIm;
        prodIR = bIm * twRe;
        // each product drops its fraction before the sum
        tProd.re = sampleT'(prodRR >>> `FFT_FRAC) - sampleT'(prodII >>> `FFT_FRAC);
        tProd.im = sampleT'(prodRI >>> `FFT_FRAC) + sampleT'(prodIR >>> `FFT_FRAC);
    end

    // addresses ride along with the data
    // only the issue bits are cleared on reset
    always_ff @(posedge clk)
    begin
        reqD1 <= req_i;
        reqD2 <= reqD1;
        tReg  <= tProd;
        aReg  <= a_i;
        if (reset_i)
        begin
            reqD1.issue <= 1'b0;
            reqD2.issue <= 1'b0;
        end
    end

    //////////////////////////////
    // stage 2 halved sum and difference
    //////////////////////////////

    // 16 bit wrap then floor halving
    always_comb
    begin
        sumRe = aReg.re + tReg.re;
        sumIm = aReg.im + tReg.im;
        difRe = aReg.re - tReg.re;
        difIm = aReg.im - tReg.im;
        res_o.write   = reqD2.issue;
        res_o.addrA   = reqD2.addrA;
        res_o.addrB   = reqD2.addrB;
        res_o.resA.re = sumRe >>> 1;
        res_o.resA.im = sumIm >>> 1;
        res_o.resB.re = difRe >>> 1;
        res_o.resB.im = difIm >>> 1;
    end

endmodule

`default_nettype wire

// File: logic/fft_sample_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_params.svh"

module fft_sample_ram
(
    input  wire logic             clk,
    input  wire logic             inFire_i,
    input  wire fft_pkg::addrT    loadAddr_i,
    input  wire fft_pkg::cplxT    in_sample_i,
    input  wire fft_pkg::bflyReqT req_i,
    input  wire fft_pkg::bflyResT res_i,
    input  wire fft_pkg::addrT    unloadAddr_i,
    output fft_pkg::cplxT         rdA_o,
    output fft_pkg::cplxT         rdB_o,
    output fft_pkg::cplxT         unloadData_o
);
    import fft_pkg::*;

    // one frame, transformed in place
    cplxT mem [`FFT_N];
    addrT revAddr;

    // bit reversed load order
    // so the stages finish in natural order
    always_comb
    begin
        for (int i = 0; i < `FFT_LOG2N; i++)
            revAddr[i] = loadAddr_i[`FFT_LOG2N - 1 - i];
    end

    //////////////////////////////
    // write ports
    //////////////////////////////

    // load and butterfly writes never overlap in time
    always_ff @(posedge clk)
    begin
        if (inFire_i)
            mem[revAddr] <= in_sample_i;
        if (res_i.write)
        begin
            mem[res_i.addrA] <= res_i.resA;
            mem[res_i.addrB] <= res_i.resB;
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // registered reads
    // data shows up the cycle after the address
    always_ff @(posedge clk)
    begin
        if (req_i.issue)
        begin
            rdA_o <= mem[req_i.addrA];
            rdB_o <= mem[req_i.addrB];
        end
        unloadData_o <= mem[unloadAddr_i];
    end

endmodule

`default_nettype wire

// File: logic/fft_addr_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_params.svh"

module fft_addr_counter
(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire fft_pkg::fftStateT  state_i,
    input  wire logic               inFire_i,
    input  wire logic               outFire_i,
    output logic                    loadDone_o,
    output logic                    stageDone_o,
    output logic                    drainDone_o,
    output logic                    lastStage_o,
    output logic                    unloadDone_o,
    output fft_pkg::addrT           loadAddr_o,
    output fft_pkg::addrT           unloadAddr_o,
    output fft_pkg::bflyReqT        req_o
);
    import fft_pkg::*;

    addrT                  loadCnt;
    addrT                  unloadCnt;
    logic [`FFT_LOG2N-2:0] bflyCnt;
    stageT                 stage;
    logic                  drainCnt;
    addrT                  kExt;
    addrT                  lowMask;
    addrT                  addrA;

    // end of phase pulses
    assign loadDone_o   = inFire_i && (loadCnt == addrT'(`FFT_N - 1));
    assign stageDone_o  = (state_i == COMPUTE) && (&bflyCnt);
    assign drainDone_o  = (state_i == DRAIN) && drainCnt;
    assign lastStage_o  = (stage == stageT'(`FFT_LOG2N - 1));
    assign unloadDone_o = outFire_i && (unloadCnt == addrT'(`FFT_N - 1));

    assign loadAddr_o = loadCnt;
    // look one bin ahead on a transfer so the read lands in time
    assign unloadAddr_o = outFire_i ? unloadCnt + 1'b1 : unloadCnt;

    // every counter wraps to zero at the end of its phase
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            loadCnt   <= '0;
            unloadCnt <= '0;
            bflyCnt   <= '0;
            stage     <= '0;
            drainCnt  <= 1'b0;
        end
        else
        begin
            if (inFire_i)
                loadCnt <= loadCnt + 1'b1;
            if (state_i == COMPUTE)
                bflyCnt <= bflyCnt + 1'b1;
            if (state_i == DRAIN)
                drainCnt <= ~drainCnt;
            if (drainDone_o)
                stage <= lastStage_o ? '0 : stage + 1'b1;
            if (outFire_i)
                unloadCnt <= unloadCnt + 1'b1;
        end
    end

    //////////////////////////////
    // DIT pair addressing
    //////////////////////////////

    // span is 1 << stage
    // addrA inserts a zero bit at position stage into the butterfly index
    // twiddle step halves as the span doubles
    always_comb
    begin
        kExt        = addrT'(bflyCnt);
        lowMask     = addrT'((1 << stage) - 1);
        addrA       = ((kExt & ~lowMask) << 1) | (kExt & lowMask);
        req_o.issue = (state_i == COMPUTE);
        req_o.addrA = addrA;
        req_o.addrB = addrA | addrT'(1 << stage);
        req_o.twIdx = twIdxT'((kExt & lowMask) << (`FFT_LOG2N - 1 - stage));
    end

    // drain starts right after the fourth butterfly of a stage
    stageAligned: assert property (@(posedge clk) disable iff (reset_i)
        (state_i == DRAIN) |-> (bflyCnt == '0));

endmodule

`default_nettype wire

// File: logic/fft_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fft_ctrl
(
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire logic         loadDone_i,
    input  wire logic         stageDone_i,
    input  wire logic         drainDone_i,
    input  wire logic         lastStage_i,
    input  wire logic         unloadDone_i,
    output fft_pkg::fftStateT state_o
);
    import fft_pkg::*;

    fftStateT nextState;

    //////////////////////////////
    // phase sequencing
    //////////////////////////////

    always_comb
    begin
        nextState = state_o;
        case (state_o)
            // ready is already up in idle
            // so the eighth sample may land in either state
            IDLE, LOAD:
            begin
                if (loadDone_i)
                    nextState = COMPUTE;
                else
                    nextState = LOAD;
            end
            // four butterflies per stage
            COMPUTE:
            begin
                if (stageDone_i)
                    nextState = DRAIN;
            end
            // wait for the two in-flight results to land
            DRAIN:
            begin
                if (drainDone_i)
                begin
                    if (lastStage_i)
                        nextState = UNLOAD;
                    else
                        nextState = COMPUTE;
                end
            end
            // leave only on the last accepted bin
            UNLOAD:
            begin
                if (unloadDone_i)
                    nextState = IDLE;
            end
            default:
            begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
            state_o <= IDLE;
        else
            state_o <= nextState;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // the final bin is only ever taken while unloading
    unloadDoneInPhase: assert property (@(posedge clk) disable iff (reset_i)
        unloadDone_i |-> (state_o == UNLOAD));

endmodule

`default_nettype wire

// File: logic/fft_pkg.sv
`default_nettype none

`include "fft_params.svh"

package fft_pkg;

    // one signed I or Q value
    typedef logic signed [`FFT_DW-1:0] sampleT;

    // complex sample, real part in the upper half
    typedef struct packed {
        sampleT re;
        sampleT im;
    } cplxT;

    // frame memory index
    typedef logic [`FFT_LOG2N-1:0] addrT;
    // stage number
    typedef logic [$clog2(`FFT_LOG2N + 1)-1:0] stageT;
    // one signed Q1.14 twiddle component
    typedef logic signed [`FFT_TW-1:0] twiddleT;
    // index into the half-size twiddle table
    typedef logic [`FFT_LOG2N-2:0] twIdxT;

    typedef enum logic [2:0] {IDLE, LOAD, COMPUTE, DRAIN, UNLOAD} fftStateT;

    // butterfly issue from the counter
    typedef struct packed {
        logic  issue;
        addrT  addrA;
        addrT  addrB;
        twIdxT twIdx;
    } bflyReqT;

    // butterfly result back to memory
    typedef struct packed {
        logic write;
        addrT addrA;
        addrT addrB;
        cplxT resA;
        cplxT resB;
    } bflyResT;

endpackage

`default_nettype wire

// File: include/fft_params.svh
`ifndef FFT_PARAMS_SVH
`define FFT_PARAMS_SVH

//////////////////////////////
// transform size
//////////////////////////////

// log2 of the point count
`define FFT_LOG2N 3
// point count
`define FFT_N (1 << `FFT_LOG2N)

//////////////////////////////
// arithmetic widths
//////////////////////////////

// one I or Q component of a sample
`define FFT_DW 16
// twiddle component width
`define FFT_TW 16
// twiddles are Q1.14
`define FFT_FRAC 14

`endif
